/* periph_subsys.f */
logic/periph_pkg.sv
logic/apb_decoder.sv
logic/plic_target.sv
logic/plic_regs.sv
logic/gpio_regs.sv
logic/periph_subsys.sv
sim/tb_periph_subsys.sv

/* Bender.yml */
package:
  name: periph_subsys

sources:
  - logic/periph_pkg.sv
  - logic/apb_decoder.sv
  - logic/plic_target.sv
  - logic/plic_regs.sv
  - logic/gpio_regs.sv
  - logic/periph_subsys.sv
  - target: simulation
    files:
      - sim/tb_periph_subsys.sv

/* sim/tb_periph_subsys.sv */
// Random-stimulus testbench for the peripheral subsystem.
// APB transfers, interrupt sources and DIP switches come from an LFSR;
// reads, pending bits and interrupt lines are compared with a model.
module tb_periph_subsys;
   timeunit 1ns;
   timeprecision 1ps;
   import periph_pkg::*;

   localparam int NumRegOps = 300;
   localparam int NumErrOps = 40;
   localparam int NumRounds = 150;
   // Readback takes 45 reads and a round at most 10 transfers with its waits
   localparam int NumTransfers = NumRegOps + NumErrOps + 45 + NumRounds * 10;

   logic                  clk_i;
   logic                  rst_i;
   logic                  psel_i;
   logic                  penable_i;
   logic                  pwrite_i;
   paddr_t                paddr_i;
   pdata_t                pwdata_i;
   logic [NumSources-2:0] irq_src_i;
   gpio_t                 dip_switches_i;
   pdata_t                prdata_o;
   logic                  pready_o;
   logic                  pslverr_o;
   logic [NumTargets-1:0] irq_o;
   gpio_t                 leds_o;

   // Model state
   prio_t               m_prio [NumSources+1];  // Entry 0 stays 0
   logic [NumSources:0] m_en [NumTargets];
   prio_t               m_thresh [NumTargets];
   logic [NumSources:0] m_pend;
   logic [NumSources:0] m_insvc;
   gpio_t               m_led;
   gpio_t               m_mask;
   gpio_t               m_stat;
   gpio_t               m_sw;
   logic [31:0]         lfsr = 32'd9;

   periph_subsys #(
      .NumSources ( NumSources ),
      .NumTargets ( NumTargets )
   ) UUT (.*);

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   initial begin
      repeat (NumTransfers * 16 + 1000) @(posedge clk_i);
      $display("timeout: the test did not finish in the expected time");
      $display("ERRORS FOUND");
      $fatal(1, "watchdog expired");
   end

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
      end
      return r;
   endfunction

   task automatic stop_on_error(input string msg);
      $display("error %0t: %s", $time, msg);
      $display("ERRORS FOUND");
      $fatal(1, "first mismatch");
   endtask

   task automatic check_data(input pdata_t got, input pdata_t exp, input string what);
      if (got !== exp) stop_on_error($sformatf("%s is %h, expected %h", what, got, exp));
   endtask

   task automatic compare_id(input irq_id_t got, input irq_id_t exp, input string what);
      if (got !== exp) stop_on_error($sformatf("%s is %0d, expected %0d", what, got, exp));
   endtask

   task automatic verify_gpio(input gpio_t got, input gpio_t exp, input string what);
      if (got !== exp) stop_on_error($sformatf("%s is %h, expected %h", what, got, exp));
   endtask

   task automatic match_lines(input logic [NumTargets-1:0] got,
                              input logic [NumTargets-1:0] exp, input string what);
      if (got !== exp) stop_on_error($sformatf("%s is %b, expected %b", what, got, exp));
   endtask

   task automatic expect_flag(input logic got, input logic exp, input string what);
      if (got !== exp) stop_on_error($sformatf("%s is %b, expected %b", what, got, exp));
   endtask

   // ---------------------------------------------------------------------
   // APB transfers
   // ---------------------------------------------------------------------
   task automatic apb_transfer(input logic wr, input paddr_t addr, input pdata_t wdata,
                               input logic exp_err, output pdata_t rdata);
      @(posedge clk_i);
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      pwrite_i  <= wr;
      paddr_i   <= addr;
      pwdata_i  <= wdata;
      @(posedge clk_i);
      penable_i <= 1'b1;
      @(negedge clk_i);  // Middle of the access cycle
      expect_flag(pready_o, 1'b1, $sformatf("pready_o at %h", addr));
      expect_flag(pslverr_o, exp_err, $sformatf("pslverr_o at %h", addr));
      rdata = prdata_o;
      @(posedge clk_i);  // Ends the access cycle
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
   endtask

   task automatic apb_write(input paddr_t addr, input pdata_t wdata, input logic exp_err);
      pdata_t unused;
      apb_transfer(1'b1, addr, wdata, exp_err, unused);
   endtask

   task automatic apb_read(input paddr_t addr, output pdata_t rdata, input logic exp_err);
      apb_transfer(1'b0, addr, '0, exp_err, rdata);
   endtask

   // Highest priority pending enabled ID above the threshold with ties to the lower ID
   function automatic irq_id_t best_id(input int t);
      irq_id_t id;
      prio_t   top;
      id  = '0;
      top = m_thresh[t];
      for (int i = 1; i <= NumSources; i++) begin
         if (m_pend[i] && m_en[t][i] && (m_prio[i] > top)) begin
            id  = irq_id_t'(i);
            top = m_prio[i];
         end
      end
      return id;
   endfunction

   function automatic logic [NumTargets-1:0] expected_lines();
      logic [NumTargets-1:0] v;
      for (int t = 0; t < NumTargets; t++) begin
         v[t] = (best_id(t) != '0);
      end
      return v;
   endfunction

   // Long enough for a switch change to reach the pending bits and the lines
   task automatic settle();
      logic [NumSources:0] req;
      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      req    = {irq_src_i, |m_stat, 1'b0};
      m_pend = m_pend | (req & ~m_insvc);
      match_lines(irq_o, expected_lines(), "irq_o");
   endtask

   // Kind 0 is priority, 1 enable, 2 threshold, 3 LED and 4 mask
   task automatic reg_access(input int kind, input int idx, input logic wr);
      paddr_t addr;
      pdata_t wdata;
      pdata_t exp;
      pdata_t got;
      int     t;
      wdata = rand_bits(32);
      t     = idx % NumTargets;
      case (kind)
         0: begin
            idx  = idx % (NumSources + 1);
            addr = PlicBase + PlicPrioOff + 4 * idx;
            if (wr && (idx != 0)) begin
               m_prio[idx] = prio_t'(wdata);  // ID 0 ignores writes
            end
            exp = pdata_t'(m_prio[idx]);
         end
         1: begin
            addr = PlicBase + PlicEnOff + 4 * t;
            if (wr) begin
               m_en[t] = {wdata[NumSources:1], 1'b0};
            end
            exp = pdata_t'(m_en[t]);
         end
         2: begin
            addr = PlicBase + PlicThreshOff + 8 * t;
            if (wr) begin
               m_thresh[t] = prio_t'(wdata);
            end
            exp = pdata_t'(m_thresh[t]);
         end
         3: begin
            addr = GpioBase + GpioLedOff;
            if (wr) begin
               m_led = gpio_t'(wdata);
            end
            exp = pdata_t'(m_led);
         end
         default: begin
            addr = GpioBase + GpioMaskOff;
            if (wr) begin
               m_mask = gpio_t'(wdata);
            end
            exp = pdata_t'(m_mask);
         end
      endcase
      if (wr) begin
         apb_write(addr, wdata, 1'b0);
      end else begin
         apb_read(addr, got, 1'b0);
         check_data(got, exp, $sformatf("register at %h", addr));
      end
      @(negedge clk_i);
      verify_gpio(leds_o, m_led, "leds_o");
   endtask

   initial begin
      irq_id_t exp_id;
      irq_id_t cid;
      paddr_t  addr;
      pdata_t  got;
      gpio_t   new_sw;
      gpio_t   clr;
      int      tgt;
      rst_i          <= 1'b1;
      psel_i         <= 1'b0;
      penable_i      <= 1'b0;
      pwrite_i       <= 1'b0;
      paddr_i        <= '0;
      pwdata_i       <= '0;
      irq_src_i      <= '0;
      dip_switches_i <= '0;
      for (int i = 0; i <= NumSources; i++) begin
         m_prio[i] = '0;
      end
      for (int t = 0; t < NumTargets; t++) begin
         m_en[t]     = '0;
         m_thresh[t] = '0;
      end
      m_pend  = '0;
      m_insvc = '0;
      m_led   = '0;
      m_mask  = '0;
      m_stat  = '0;
      m_sw    = '0;
      repeat (2) @(posedge clk_i);
      rst_i <= 1'b0;
      @(negedge clk_i);
      match_lines(irq_o, '0, "irq_o after reset");
      verify_gpio(leds_o, '0, "leds_o after reset");

      // ------------------------------------------------------------------
      // Register traffic, then unmapped blocks
      // ------------------------------------------------------------------
      repeat (NumRegOps) begin
         reg_access(rand_bits(3) % 5, rand_bits(4), rand_bits(1));
      end
      repeat (NumErrOps) begin
         addr        = rand_bits(32);
         addr[15:12] = 4'(2 + rand_bits(4) % 14);
         if (rand_bits(1)) begin
            apb_write(addr, rand_bits(32), 1'b1);
         end else begin
            apb_read(addr, got, 1'b1);
            check_data(got, ErrData, "unmapped read");
         end
      end
      for (int k = 0; k < 5; k++) begin
         for (int i = 0; i <= NumSources; i++) begin
            reg_access(k, i, 1'b0);  // Nothing moved
         end
      end

      // ------------------------------------------------------------------
      // Interrupt sources, switches, claim and complete
      // ------------------------------------------------------------------
      repeat (NumRounds) begin
         reg_access(rand_bits(3) % 5, rand_bits(4), rand_bits(1));
         if (rand_bits(2) == 0) begin
            m_mask = gpio_t'(rand_bits(8));
            apb_write(GpioBase + GpioMaskOff, pdata_t'(m_mask), 1'b0);
         end
         new_sw = gpio_t'(rand_bits(8));
         @(posedge clk_i);
         irq_src_i      <= rand_bits(NumSources - 1);
         dip_switches_i <= new_sw;
         m_stat = m_stat | ((new_sw ^ m_sw) & m_mask);
         m_sw   = new_sw;
         settle();
         apb_read(GpioBase + GpioSwOff, got, 1'b0);
         verify_gpio(gpio_t'(got), m_sw, "switch register");
         apb_read(GpioBase + GpioStatOff, got, 1'b0);
         verify_gpio(gpio_t'(got), m_stat, "status register");
         apb_read(PlicBase + PlicPendOff, got, 1'b0);
         check_data(got, pdata_t'(m_pend), "pending register");

         // Clear status before completing so that source 1 is stable
         clr = gpio_t'(rand_bits(8));
         apb_write(GpioBase + GpioStatOff, pdata_t'(clr), 1'b0);
         m_stat = m_stat & ~clr;

         tgt    = rand_bits(1);
         exp_id = best_id(tgt);
         apb_read(PlicBase + PlicClaimOff + 8 * tgt, got, 1'b0);
         compare_id(irq_id_t'(got), exp_id, $sformatf("claim of target %0d", tgt));
         if (exp_id != '0) begin
            m_pend[exp_id]  = 1'b0;
            m_insvc[exp_id] = 1'b1;
         end
         cid = rand_bits(1) ? exp_id : irq_id_t'(rand_bits(4));
         apb_write(PlicBase + PlicClaimOff + 8 * tgt, pdata_t'(cid), 1'b0);
         if ((cid != '0) && (cid <= NumSources)) begin
            m_insvc[cid] = 1'b0;
         end
         settle();
      end

      $display("NO ERRORS");
      $finish;
   end

endmodule

/* logic/periph_subsys.sv */
// Peripheral subsystem top level on a single APB port.
// Connects the address decoder, the PLIC and the GPIO block; the GPIO
// change interrupt is PLIC source 1, irq_src_i feeds sources 2 and up.
module periph_subsys #(
   parameter int NumSources = periph_pkg::NumSources,
   parameter int NumTargets = periph_pkg::NumTargets
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  periph_pkg::paddr_t    paddr_i,
   input  periph_pkg::pdata_t    pwdata_i,
   input  logic [NumSources-2:0] irq_src_i,
   input  periph_pkg::gpio_t     dip_switches_i,
   output periph_pkg::pdata_t    prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o,
   output logic [NumTargets-1:0] irq_o,
   output periph_pkg::gpio_t     leds_o
);
   import periph_pkg::*;

   logic   plic_sel;
   logic   gpio_sel;
   pdata_t plic_rdata;
   pdata_t gpio_rdata;
   logic   gpio_irq;

   apb_decoder i_apb_decoder (
      .clk_i        ( clk_i      ),
      .rst_i        ( rst_i      ),
      .psel_i       ( psel_i     ),
      .penable_i    ( penable_i  ),
      .paddr_i      ( paddr_i    ),
      .plic_rdata_i ( plic_rdata ),
      .gpio_rdata_i ( gpio_rdata ),
      .plic_sel_o   ( plic_sel   ),
      .gpio_sel_o   ( gpio_sel   ),
      .prdata_o     ( prdata_o   ),
      .pready_o     ( pready_o   ),
      .pslverr_o    ( pslverr_o  )
   );

   // ----------------------------------------------------------------------
   // Interrupt controller
   // ----------------------------------------------------------------------
   plic_regs #(
      .NumSources ( NumSources ),
      .NumTargets ( NumTargets )
   ) i_plic_regs (
      .clk_i     ( clk_i                 ),
      .rst_i     ( rst_i                 ),
      .sel_i     ( plic_sel              ),
      .penable_i ( penable_i             ),
      .pwrite_i  ( pwrite_i              ),
      .offset_i  ( paddr_i[11:0]         ),
      .wdata_i   ( pwdata_i              ),
      .src_i     ( {irq_src_i, gpio_irq} ),
      .rdata_o   ( plic_rdata            ),
      .irq_o     ( irq_o                 )
   );

   // ----------------------------------------------------------------------
   // LEDs and switches
   // ----------------------------------------------------------------------
   gpio_regs i_gpio_regs (
      .clk_i     ( clk_i          ),
      .rst_i     ( rst_i          ),
      .sel_i     ( gpio_sel       ),
      .penable_i ( penable_i      ),
      .pwrite_i  ( pwrite_i       ),
      .offset_i  ( paddr_i[11:0]  ),
      .wdata_i   ( pwdata_i       ),
      .sw_i      ( dip_switches_i ),
      .rdata_o   ( gpio_rdata     ),
      .leds_o    ( leds_o         ),
      .irq_o     ( gpio_irq       )
   );

endmodule

/* logic/gpio_regs.sv */
// GPIO block: LED register, synchronized DIP switches and a
// change interrupt with mask and write-1-to-clear status.
module gpio_regs (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               sel_i,
   input  logic               penable_i,
   input  logic               pwrite_i,
   input  logic [11:0]        offset_i,
   input  periph_pkg::pdata_t wdata_i,
   input  periph_pkg::gpio_t  sw_i,
   output periph_pkg::pdata_t rdata_o,
   output periph_pkg::gpio_t  leds_o,
   output logic               irq_o
);
   import periph_pkg::*;

   gpio_t led_q;
   gpio_t mask_q;
   gpio_t stat_q;
   gpio_t sw_meta_q;   // First synchronizer stage
   gpio_t sw_sync_q;
   gpio_t sw_prev_q;
   gpio_t changed;
   gpio_t stat_clr;
   logic  wr_en;

   assign wr_en    = sel_i & penable_i & pwrite_i;
   assign changed  = (sw_sync_q ^ sw_prev_q) & mask_q;
   assign stat_clr = (wr_en && (offset_i == GpioStatOff)) ? gpio_t'(wdata_i) : '0;

   // ----------------------------------------------------------------------
   // Switch path
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sw_meta_q <= '0;
         sw_sync_q <= '0;
         sw_prev_q <= '0;
         stat_q    <= '0;
      end else begin
         sw_meta_q <= sw_i;
         sw_sync_q <= sw_meta_q;
         sw_prev_q <= sw_sync_q;
         stat_q    <= (stat_q & ~stat_clr) | changed;  // New change beats clear
      end
   end

   // LED and mask registers
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         led_q  <= '0;
         mask_q <= '0;
      end else if (wr_en) begin
         if (offset_i == GpioLedOff) begin
            led_q <= gpio_t'(wdata_i);
         end
         if (offset_i == GpioMaskOff) begin
            mask_q <= gpio_t'(wdata_i);
         end
      end
   end

   always_comb begin
      case (offset_i)
         GpioLedOff:  rdata_o = pdata_t'(led_q);
         GpioSwOff:   rdata_o = pdata_t'(sw_sync_q);
         GpioMaskOff: rdata_o = pdata_t'(mask_q);
         GpioStatOff: rdata_o = pdata_t'(stat_q);
         default:     rdata_o = '0;
      endcase
   end

   assign leds_o = led_q;
   assign irq_o  = |stat_q;  // PLIC source 1

endmodule

/* logic/plic_regs.sv */
// PLIC register file: gateways, pending and in-service bits, priorities,
// per-target enables and thresholds, claim and complete.
// Source ID n is fed by src_i[n-1]; ID 0 is reserved.
module plic_regs #(
   parameter int NumSources = periph_pkg::NumSources,
   parameter int NumTargets = periph_pkg::NumTargets
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  sel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  logic [11:0]           offset_i,
   input  periph_pkg::pdata_t    wdata_i,
   input  logic [NumSources-1:0] src_i,
   output periph_pkg::pdata_t    rdata_o,
   output logic [NumTargets-1:0] irq_o
);
   import periph_pkg::*;

   prio_t [NumSources:0] prio_q;
   logic  [NumSources:0] pending_q;
   logic  [NumSources:0] in_service_q;
   logic  [NumSources:0] enable_q [NumTargets];
   prio_t                thresh_q [NumTargets];
   irq_id_t              best_id  [NumTargets];

   logic       wr_en;
   logic       rd_en;
   logic [5:0] src_idx;   // Word index, priority and enable
   logic [4:0] ctx_idx;   // Threshold/claim pair
   logic       prio_hit;
   logic       pend_hit;
   logic       en_hit;
   logic       ctx_hit;
   logic       thresh_sel;
   logic       claim_sel;
   logic       claim_rd;
   logic       complete_wr;
   irq_id_t    claim_id;
   irq_id_t    complete_id;

   // ----------------------------------------------------------------------
   // Register decode
   // ----------------------------------------------------------------------
   assign wr_en   = sel_i & penable_i & pwrite_i;
   assign rd_en   = sel_i & penable_i & ~pwrite_i;
   assign src_idx = offset_i[7:2];
   assign ctx_idx = offset_i[7:3];

   assign prio_hit = (offset_i[11:8] == PlicPrioOff[11:8]) && (src_idx != '0) &&
                     (src_idx <= NumSources);
   assign pend_hit = (offset_i == PlicPendOff);
   assign en_hit   = (offset_i[11:8] == PlicEnOff[11:8]) && (src_idx < NumTargets);
   assign ctx_hit  = (offset_i[11:8] == PlicThreshOff[11:8]) && (ctx_idx < NumTargets);

   assign thresh_sel = ctx_hit && (offset_i[2:0] == PlicThreshOff[2:0]);
   assign claim_sel  = ctx_hit && (offset_i[2:0] == PlicClaimOff[2:0]);

   assign claim_rd    = rd_en & claim_sel;
   assign complete_wr = wr_en & claim_sel;
   assign complete_id = irq_id_t'(wdata_i);

   always_comb begin
      claim_id = '0;
      for (int t = 0; t < NumTargets; t++) begin
         if (ctx_idx == t) begin
            claim_id = best_id[t];
         end
      end
   end

   // ----------------------------------------------------------------------
   // Gateways, claim and complete
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pending_q    <= '0;
         in_service_q <= '0;
      end else begin
         for (int i = 1; i <= NumSources; i++) begin
            if (src_i[i-1] && !pending_q[i] && !in_service_q[i]) begin
               pending_q[i] <= 1'b1;  // One request per service
            end
         end
         if (claim_rd && (claim_id != '0)) begin
            pending_q[claim_id]    <= 1'b0;
            in_service_q[claim_id] <= 1'b1;
         end
         if (complete_wr && (complete_id != '0) && (complete_id <= NumSources)) begin
            in_service_q[complete_id] <= 1'b0;
         end
      end
   end

   // Priority, enable and threshold registers
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         prio_q <= '0;
         for (int t = 0; t < NumTargets; t++) begin
            enable_q[t] <= '0;
            thresh_q[t] <= '0;
         end
      end else if (wr_en) begin
         for (int i = 1; i <= NumSources; i++) begin
            if (prio_hit && (src_idx == i)) begin
               prio_q[i] <= prio_t'(wdata_i);
            end
         end
         for (int t = 0; t < NumTargets; t++) begin
            if (en_hit && (src_idx == t)) begin
               enable_q[t] <= {wdata_i[NumSources:1], 1'b0};  // ID 0 stays off
            end
            if (thresh_sel && (ctx_idx == t)) begin
               thresh_q[t] <= prio_t'(wdata_i);
            end
         end
      end
   end

   // ----------------------------------------------------------------------
   // Read data
   // ----------------------------------------------------------------------
   always_comb begin
      rdata_o = '0;
      if (prio_hit) begin
         rdata_o = pdata_t'(prio_q[src_idx]);
      end
      if (pend_hit) begin
         rdata_o = pdata_t'(pending_q);
      end
      for (int t = 0; t < NumTargets; t++) begin
         if (en_hit && (src_idx == t)) begin
            rdata_o = pdata_t'(enable_q[t]);
         end
         if (thresh_sel && (ctx_idx == t)) begin
            rdata_o = pdata_t'(thresh_q[t]);
         end
      end
      if (claim_sel) begin
         rdata_o = pdata_t'(claim_id);
      end
   end

   for (genvar t = 0; t < NumTargets; t++) begin : gen_target
      plic_target #(
         .NumSources ( NumSources )
      ) i_plic_target (
         .clk_i     ( clk_i       ),
         .rst_i     ( rst_i       ),
         .pending_i ( pending_q   ),
         .enable_i  ( enable_q[t] ),
         .prio_i    ( prio_q      ),
         .thresh_i  ( thresh_q[t] ),
         .best_id_o ( best_id[t]  ),
         .irq_o     ( irq_o[t]    )
      );
   end

   a_claim_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
      claim_rd |-> (claim_id <= NumSources))
      else $error("claimed ID beyond last source");

endmodule

/* logic/plic_target.sv */
// One PLIC interrupt target.
// Picks the strongest pending enabled source above the threshold, lower
// ID on a tie, and drives a registered interrupt line from it.
module plic_target #(
   parameter int NumSources = periph_pkg::NumSources
) (
   input  logic                             clk_i,
   input  logic                             rst_i,
   input  logic [NumSources:0]              pending_i,  // Bit 0 unused
   input  logic [NumSources:0]              enable_i,
   input  periph_pkg::prio_t [NumSources:0] prio_i,
   input  periph_pkg::prio_t                thresh_i,
   output periph_pkg::irq_id_t              best_id_o,
   output logic                             irq_o
);
   import periph_pkg::*;

   prio_t best_prio;

   // Strict compare keeps the lower ID on equal priority
   always_comb begin
      best_id_o = '0;
      best_prio = thresh_i;
      for (int i = 1; i <= NumSources; i++) begin
         if (pending_i[i] && enable_i[i] && (prio_i[i] > best_prio)) begin
            best_id_o = irq_id_t'(i);
            best_prio = prio_i[i];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         irq_o <= 1'b0;
      end else begin
         irq_o <= (best_id_o != '0);
      end
   end

endmodule

/* logic/apb_decoder.sv */
// APB address decoder for the peripheral subsystem.
// Selects the PLIC or GPIO block, muxes their read data back and answers
// every other address with a slave error.
module apb_decoder (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               psel_i,
   input  logic               penable_i,
   input  periph_pkg::paddr_t paddr_i,
   input  periph_pkg::pdata_t plic_rdata_i,
   input  periph_pkg::pdata_t gpio_rdata_i,
   output logic               plic_sel_o,
   output logic               gpio_sel_o,
   output periph_pkg::pdata_t prdata_o,
   output logic               pready_o,
   output logic               pslverr_o
);
   import periph_pkg::*;

   logic hit_plic;
   logic hit_gpio;
   logic access;

   assign hit_plic = (paddr_i[15:12] == PlicBase[15:12]);
   assign hit_gpio = (paddr_i[15:12] == GpioBase[15:12]);
   assign access   = psel_i & penable_i;

   // Held through setup and access cycles
   assign plic_sel_o = psel_i & hit_plic;
   assign gpio_sel_o = psel_i & hit_gpio;

   assign pready_o = access;  // No wait states

   // ----------------------------------------------------------------------
   // Error responder, stateless
   // ----------------------------------------------------------------------
   assign pslverr_o = access & ~(hit_plic | hit_gpio);

   always_comb begin
      if (hit_plic) begin
         prdata_o = plic_rdata_i;
      end else if (hit_gpio) begin
         prdata_o = gpio_rdata_i;
      end else begin
         prdata_o = ErrData;
      end
   end

   // ----------------------------------------------------------------------
   // Protocol checks
   // ----------------------------------------------------------------------
   a_enable_needs_sel: assert property (@(posedge clk_i) disable iff (rst_i)
      penable_i |-> psel_i)
      else $error("penable high without psel");

   a_setup_before_access: assert property (@(posedge clk_i) disable iff (rst_i)
      access |-> $past(psel_i && !penable_i))
      else $error("access cycle without a setup cycle");

endmodule

/* logic/periph_pkg.sv */
// Shared types, limits and address map of the peripheral subsystem.
// Imported by every RTL block and by the testbench.
package periph_pkg;

   typedef logic [31:0] paddr_t;   // APB byte address
   typedef logic [31:0] pdata_t;
   typedef logic [2:0]  prio_t;    // 0 never interrupts
   typedef logic [3:0]  irq_id_t;  // 0 means no source
   typedef logic [7:0]  gpio_t;

   localparam int NumSources = 8;
   localparam int NumTargets = 2;

   // ----------------------------------------------------------------------
   // Block map, decoded on address bits 15:12
   // ----------------------------------------------------------------------
   localparam paddr_t PlicBase = 32'h0000_0000;
   localparam paddr_t GpioBase = 32'h0000_1000;

   // ----------------------------------------------------------------------
   // PLIC register offsets
   // ----------------------------------------------------------------------
   localparam logic [11:0] PlicPrioOff   = 12'h000;  // 4 * ID
   localparam logic [11:0] PlicPendOff   = 12'h100;  // Read only
   localparam logic [11:0] PlicEnOff     = 12'h200;  // 4 * target
   localparam logic [11:0] PlicThreshOff = 12'h300;  // 8 * target
   localparam logic [11:0] PlicClaimOff  = 12'h304;  // 8 * target

   // ----------------------------------------------------------------------
   // GPIO register offsets
   // ----------------------------------------------------------------------
   localparam logic [11:0] GpioLedOff  = 12'h000;
   localparam logic [11:0] GpioSwOff   = 12'h004;
   localparam logic [11:0] GpioMaskOff = 12'h008;
   localparam logic [11:0] GpioStatOff = 12'h00C;  // Write 1 to clear

   // Returned for accesses to absent blocks
   localparam pdata_t ErrData = 32'hDEAD_BEEF;

endpackage
